//--- cholesky.f
chol_pkg.sv
fix_sqrt.sv
fix_div.sv
elem_unit.sv
dot_mac.sv
tri_store.sv
chol_seq.sv
cholesky_top.sv
cholesky_sva.sv
tb_cholesky.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the Cholesky testbench with Verilator, runs it and searches the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    -f cholesky.f --top-module tb_cholesky -o sim_tb > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_tb 2>&1 | tee "$LOG"

grep -q "^Regression passed$" "$LOG" && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }

//--- tb_cholesky.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cholesky;

    localparam int N          = chol_pkg::DEFAULT_N;
    localparam int T          = N * (N + 1) / 2;
    localparam int W          = chol_pkg::FIX_W;
    localparam int ONE        = 1 << chol_pkg::FRAC_W;        // 1.0 in Q16.16
    localparam int CLK_PERIOD = 20;
    localparam int NUM_RANDOM = 40;
    localparam int NUM_DIAG   = 3;
    localparam int NUM_TESTS  = NUM_RANDOM + NUM_DIAG + 5;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * N * N * 60 + 1000;

    logic           clk;
    logic           rst;
    logic [T*W-1:0] a_tri;
    logic           a_valid;
    logic [T*W-1:0] l_tri;
    logic           l_valid;

    chol_pkg::fix_t a_m   [N][N];                // Full symmetric A
    chol_pkg::fix_t l_exp [N][N];                // Expected factor
    int             errs;
    int             errors;
    int             tests_run;
    int             tests_failed;
    int             lv_seen = 0;
    int             start_cnt;

    cholesky_top #(.N(N)) UUT (
        .clk(clk), .rst(rst), .a_tri(a_tri), .a_valid(a_valid),
        .l_tri(l_tri), .l_valid(l_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(negedge clk) begin
        if (l_valid) lv_seen <= lv_seen + 1;   // Pulse count for the ignore test
    end

    // ======================================================================
    // Reference arithmetic
    // ======================================================================
    // Floor root of x * 2^16 by binary search
    function automatic chol_pkg::fix_t ref_sqrt(chol_pkg::fix_t x);
        longint unsigned v;
        longint unsigned lo;
        longint unsigned hi;
        longint unsigned mid;
        if (x < 0) return '0;
        v  = longint'(x) << chol_pkg::FRAC_W;
        lo = 0;
        hi = 64'd1 << 24;                        // Root stays below 2^24
        while (hi - lo > 1) begin
            mid = (lo + hi) >> 1;
            if (mid * mid <= v) lo = mid;
            else hi = mid;
        end
        return chol_pkg::fix_t'(lo);
    endfunction

    function automatic chol_pkg::fix_t ref_div(chol_pkg::fix_t a, chol_pkg::fix_t b);
        longint unsigned num;
        longint unsigned den;
        longint unsigned q;
        if (b == 0) return '0;
        num = (a < 0) ? -longint'(a) : longint'(a);
        den = (b < 0) ? -longint'(b) : longint'(b);
        q   = (num << chol_pkg::FRAC_W) / den;
        if ((a < 0) != (b < 0)) q = -q;           // Truncation toward zero
        return chol_pkg::fix_t'(q[31:0]);
    endfunction

    task automatic compute_model();
        longint         sum;
        chol_pkg::fix_t dot;
        chol_pkg::fix_t diff;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) l_exp[i][j] = '0;
        end
        for (int j = 0; j < N; j++) begin
            for (int i = j; i < N; i++) begin
                sum = 0;
                for (int k = 0; k < j; k++) begin
                    sum += longint'(l_exp[i][k]) * longint'(l_exp[j][k]);
                end
                dot  = chol_pkg::fix_t'(sum >>> chol_pkg::FRAC_W);   // Bits 47..16
                diff = a_m[i][j] - dot;
                l_exp[i][j] = (i == j) ? ref_sqrt(diff) : ref_div(diff, l_exp[j][j]);
            end
        end
    endtask

    // ======================================================================
    // Stimulus
    // ======================================================================
    task automatic make_spd();
        chol_pkg::fix_t b [N][N];
        longint         acc;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                if (j > i) b[i][j] = '0;
                else if (j == i) b[i][j] = ONE + int'($urandom % (3 * ONE + 1));
                else b[i][j] = int'($urandom % (4 * ONE + 1)) - 2 * ONE;
            end
        end
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j <= i; j++) begin
                acc = 0;
                for (int k = 0; k < N; k++) acc += longint'(b[i][k]) * longint'(b[j][k]);
                a_m[i][j] = chol_pkg::fix_t'(acc >>> chol_pkg::FRAC_W);
                a_m[j][i] = a_m[i][j];
            end
        end
    endtask

    task automatic make_diag(input bit identity);
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                a_m[i][j] = '0;
            end
            a_m[i][i] = identity ? ONE : ONE / 4 + int'($urandom % (16 * ONE));
        end
    endtask

    // Packs the lower triangle and pulses a_valid for one cycle
    task automatic send_matrix();
        @(negedge clk);
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j <= i; j++) a_tri[(i * (i + 1) / 2 + j) * W +: W] = a_m[i][j];
        end
        a_valid = 1'b1;
        @(negedge clk);
        a_valid = 1'b0;
    endtask

    task automatic wait_factor();
        while (l_valid !== 1'b1) @(negedge clk);
    endtask

    // ======================================================================
    // Checking
    // ======================================================================
    task automatic compare_factor(inout int e);
        chol_pkg::fix_t got;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j <= i; j++) begin
                got = l_tri[(i * (i + 1) / 2 + j) * W +: W];
                if (got !== l_exp[i][j]) begin
                    $display("FAILED %0t: L[%0d][%0d] = %08h, expected %08h",
                             $time, i, j, got, l_exp[i][j]);
                    e++;
                end
            end
        end
    endtask

    task automatic finish_test(input string name, input int e);
        tests_run++;
        errors += e;
        if (e == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, e);
            tests_failed++;
        end
    endtask

    task automatic run_checked(input string name);
        compute_model();
        send_matrix();
        wait_factor();
        errs = 0;
        compare_factor(errs);
        finish_test(name, errs);
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        void'($urandom(81654));
        rst = 1'b1;
        a_valid = 1'b0;
        a_tri = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        errs = 0;                                // Idle outputs after reset
        repeat (10) begin
            @(negedge clk);
            if (l_valid !== 1'b0) begin
                $display("FAILED %0t: l_valid high before any matrix", $time);
                errs++;
            end
            if (l_tri !== '0) begin
                $display("FAILED %0t: l_tri not zero after reset", $time);
                errs++;
            end
        end
        finish_test("reset idle", errs);

        for (int t = 0; t < NUM_RANDOM; t++) begin
            make_spd();
            run_checked($sformatf("random %0d", t));
        end

        make_spd();                              // Busy pulses must be ignored
        compute_model();
        send_matrix();
        start_cnt = lv_seen;
        make_spd();
        repeat (3) begin
            repeat (5) @(negedge clk);
            send_matrix();
        end
        wait_factor();
        errs = 0;
        compare_factor(errs);
        repeat (N * N * 60) @(negedge clk);     // Room for a stray second result
        if (lv_seen - start_cnt != 1) begin
            $display("FAILED %0t: %0d l_valid pulses, expected 1", $time, lv_seen - start_cnt);
            errs++;
        end
        finish_test("ignore busy a_valid", errs);

        for (int t = 0; t < NUM_DIAG; t++) begin
            make_diag(t == 0);
            compute_model();
            send_matrix();
            wait_factor();
            errs = 0;
            compare_factor(errs);
            for (int i = 1; i < N; i++) begin
                for (int j = 0; j < i; j++) begin
                    if (l_tri[(i * (i + 1) / 2 + j) * W +: W] !== '0) begin
                        $display("FAILED %0t: diagonal L[%0d][%0d] not zero", $time, i, j);
                        errs++;
                    end
                end
            end
            finish_test($sformatf("diagonal %0d", t), errs);
        end

        make_spd();                              // Zero first pivot
        a_m[0][0] = '0;
        compute_model();
        send_matrix();
        wait_factor();
        errs = 0;
        compare_factor(errs);
        for (int i = 0; i < N; i++) begin
            if (l_tri[(i * (i + 1) / 2) * W +: W] !== '0) begin
                $display("FAILED %0t: L[%0d][0] not zero with zero pivot", $time, i);
                errs++;
            end
        end
        finish_test("zero pivot", errs);

        make_spd();                              // Second matrix starts right after l_valid
        run_checked("back to back first");
        make_spd();
        run_checked("back to back second");

        $display("Tests run %0d, failed %0d, element errors %0d",
                 tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: no l_valid within %0d cycles", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- cholesky_sva.sv
`timescale 1ns/1ps
`default_nettype none

module cholesky_sva #(
    parameter int N = chol_pkg::DEFAULT_N
) (
    input logic                                   clk,
    input logic                                   rst,
    input logic                                   a_valid,
    input logic                                   l_valid,
    input logic [N*(N+1)/2*chol_pkg::FIX_W-1:0]   l_tri
);

    logic running;                               // Matrix accepted, result not out yet

    always_ff @(posedge clk) begin
        if (rst || l_valid) begin
            running <= 1'b0;
        end else if (a_valid) begin
            running <= 1'b1;
        end
    end

    // ======================================================================
    // Output pulse and factor stability
    // ======================================================================
    single_pulse: assert property (@(posedge clk) disable iff (rst) l_valid |=> !l_valid)
        else $error("l_valid high two cycles in a row");

    quiet_after_reset: assert property (@(posedge clk) rst |=> !l_valid)
        else $error("l_valid high in the cycle after reset");

    stable_factor: assert property (@(posedge clk) disable iff (rst)
        $changed(l_tri) |-> $past(a_valid || running || rst))
        else $error("l_tri changed while idle");

endmodule

bind cholesky_top cholesky_sva #(.N(N)) u_sva (
    .clk(clk), .rst(rst), .a_valid(a_valid), .l_valid(l_valid), .l_tri(l_tri)
);

`default_nettype wire

//--- cholesky_top.sv
`timescale 1ns/1ps
`default_nettype none

module cholesky_top #(
    parameter int N = chol_pkg::DEFAULT_N
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [N*(N+1)/2*chol_pkg::FIX_W-1:0]   a_tri,
    input  logic                                   a_valid,
    output logic [N*(N+1)/2*chol_pkg::FIX_W-1:0]   l_tri,
    output logic                                   l_valid
);

    logic                  capture;
    chol_pkg::idx_t        rd_row;
    chol_pkg::idx_t        rd_col;
    chol_pkg::idx_t        rd_term;
    chol_pkg::fix_t        rd_a;
    chol_pkg::fix_t        rd_l0;                // L_ik
    chol_pkg::fix_t        rd_l1;                // L_jk
    chol_pkg::fix_t        rd_piv;               // L_jj
    logic                  wr_en;
    chol_pkg::idx_t [1:0]  wr_idx;
    chol_pkg::fix_t        wr_data;
    logic                  mac_clear;
    logic                  mac_step;
    chol_pkg::fix_t        mac_x;
    chol_pkg::fix_t        mac_y;
    chol_pkg::acc_t        mac_sum;
    logic                  req_valid;
    chol_pkg::elem_req_t   req;
    logic                  res_valid;
    chol_pkg::fix_t        res;

    chol_seq #(.N(N)) u_seq (
        .clk(clk), .rst(rst), .a_valid(a_valid),
        .mac_sum(mac_sum), .res_valid(res_valid), .res(res),
        .rd_a(rd_a), .rd_l0(rd_l0), .rd_l1(rd_l1), .rd_piv(rd_piv),
        .capture(capture), .rd_row(rd_row), .rd_col(rd_col), .rd_term(rd_term),
        .mac_clear(mac_clear), .mac_step(mac_step), .mac_x(mac_x), .mac_y(mac_y),
        .req_valid(req_valid), .req(req),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data), .l_valid(l_valid)
    );

    tri_store #(.N(N)) u_store (
        .clk(clk), .rst(rst), .capture(capture), .a_tri(a_tri),
        .rd_row(rd_row), .rd_col(rd_col), .rd_term(rd_term),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
        .rd_a(rd_a), .rd_l0(rd_l0), .rd_l1(rd_l1), .rd_piv(rd_piv), .l_tri(l_tri)
    );

    dot_mac u_mac (
        .clk(clk), .rst(rst), .mac_clear(mac_clear), .mac_step(mac_step),
        .mac_x(mac_x), .mac_y(mac_y), .mac_sum(mac_sum)
    );

    elem_unit u_elem (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req(req),
        .res_valid(res_valid), .res(res)
    );

endmodule

`default_nettype wire

//--- chol_seq.sv
`timescale 1ns/1ps
`default_nettype none

module chol_seq #(
    parameter int N = chol_pkg::DEFAULT_N
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  a_valid,
    input  chol_pkg::acc_t        mac_sum,
    input  logic                  res_valid,
    input  chol_pkg::fix_t        res,
    input  chol_pkg::fix_t        rd_a,
    input  chol_pkg::fix_t        rd_l0,
    input  chol_pkg::fix_t        rd_l1,
    input  chol_pkg::fix_t        rd_piv,
    output logic                  capture,
    output chol_pkg::idx_t        rd_row,
    output chol_pkg::idx_t        rd_col,
    output chol_pkg::idx_t        rd_term,
    output logic                  mac_clear,
    output logic                  mac_step,
    output chol_pkg::fix_t        mac_x,
    output chol_pkg::fix_t        mac_y,
    output logic                  req_valid,
    output chol_pkg::elem_req_t   req,
    output logic                  wr_en,
    output chol_pkg::idx_t [1:0]  wr_idx,
    output chol_pkg::fix_t        wr_data,
    output logic                  l_valid
);

    localparam chol_pkg::idx_t LAST = chol_pkg::idx_t'(N - 1);
    localparam int DOT_LSB = chol_pkg::FRAC_W;
    localparam int DOT_MSB = chol_pkg::FIX_W + chol_pkg::FRAC_W - 1;

    chol_pkg::seq_state_e state_q;
    chol_pkg::idx_t       col_q;                 // j
    chol_pkg::idx_t       row_q;                 // i, from j to N-1
    chol_pkg::idx_t       term_q;                // k, below j
    chol_pkg::fix_t       res_q;

    // ======================================================================
    // Column, row and term sequencing
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= chol_pkg::IDLE;
            col_q   <= '0;
            row_q   <= '0;
            term_q  <= '0;
        end else begin
            case (state_q)
                chol_pkg::IDLE: begin
                    if (a_valid) begin
                        col_q   <= '0;
                        row_q   <= '0;
                        state_q <= chol_pkg::DOT_CLEAR;
                    end
                end
                chol_pkg::DOT_CLEAR: begin
                    term_q  <= '0;
                    state_q <= (col_q == '0) ? chol_pkg::DOT_WAIT : chol_pkg::DOT_STEP;
                end
                chol_pkg::DOT_STEP: begin
                    term_q <= term_q + 1'b1;
                    if (term_q + 1'b1 == col_q) begin
                        state_q <= chol_pkg::DOT_WAIT; // Last term k = j-1
                    end
                end
                chol_pkg::DOT_WAIT:   state_q <= chol_pkg::ELEM_ISSUE;
                chol_pkg::ELEM_ISSUE: state_q <= chol_pkg::ELEM_WAIT;
                chol_pkg::ELEM_WAIT: begin
                    if (res_valid) begin
                        state_q <= chol_pkg::WRITE;
                    end
                end
                chol_pkg::WRITE: begin
                    if (row_q != LAST) begin
                        row_q   <= row_q + 1'b1;
                        state_q <= chol_pkg::DOT_CLEAR;
                    end else if (col_q != LAST) begin
                        col_q   <= col_q + 1'b1;
                        row_q   <= col_q + 1'b1;   // Next column starts on its diagonal
                        state_q <= chol_pkg::DOT_CLEAR;
                    end else begin
                        state_q <= chol_pkg::DONE;
                    end
                end
                default: state_q <= chol_pkg::IDLE;  // DONE
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == chol_pkg::ELEM_WAIT && res_valid) begin
            res_q <= res;
        end
    end

    // ======================================================================
    // Strobes and operands
    // ======================================================================
    always_comb begin
        capture   = 1'b0;
        mac_clear = 1'b0;
        mac_step  = 1'b0;
        req_valid = 1'b0;
        wr_en     = 1'b0;
        l_valid   = 1'b0;
        case (state_q)
            chol_pkg::IDLE:       capture   = a_valid;
            chol_pkg::DOT_CLEAR:  mac_clear = 1'b1;
            chol_pkg::DOT_STEP:   mac_step  = 1'b1;
            chol_pkg::ELEM_ISSUE: req_valid = 1'b1;
            chol_pkg::WRITE:      wr_en     = 1'b1;
            chol_pkg::DONE:       l_valid   = 1'b1;
            default: ;
        endcase
    end

    assign rd_row  = row_q;
    assign rd_col  = col_q;
    assign rd_term = term_q;
    assign mac_x   = rd_l0;                      // L_ik
    assign mac_y   = rd_l1;                      // L_jk

    assign req.is_diag = (row_q == col_q);
    assign req.a_elem  = rd_a;
    assign req.dot     = mac_sum[DOT_MSB:DOT_LSB];
    assign req.pivot   = rd_piv;

    assign wr_idx  = {row_q, col_q};
    assign wr_data = res_q;

endmodule

`default_nettype wire

//--- tri_store.sv
`timescale 1ns/1ps
`default_nettype none

module tri_store #(
    parameter int N = chol_pkg::DEFAULT_N
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   capture,
    input  logic [N*(N+1)/2*chol_pkg::FIX_W-1:0]   a_tri,
    input  chol_pkg::idx_t                         rd_row,
    input  chol_pkg::idx_t                         rd_col,
    input  chol_pkg::idx_t                         rd_term,
    input  logic                                   wr_en,
    input  chol_pkg::idx_t [1:0]                   wr_idx,
    input  chol_pkg::fix_t                         wr_data,
    output chol_pkg::fix_t                         rd_a,
    output chol_pkg::fix_t                         rd_l0,
    output chol_pkg::fix_t                         rd_l1,
    output chol_pkg::fix_t                         rd_piv,
    output logic [N*(N+1)/2*chol_pkg::FIX_W-1:0]   l_tri
);

    localparam int T = N * (N + 1) / 2;          // Elements in a triangle
    localparam int W = chol_pkg::FIX_W;

    chol_pkg::fix_t a_mem [T];
    chol_pkg::fix_t l_mem [T];

    // Element (r,c) with r >= c
    function automatic int tri_idx(chol_pkg::idx_t r, chol_pkg::idx_t c);
        return int'(r) * (int'(r) + 1) / 2 + int'(c);
    endfunction

    always_ff @(posedge clk) begin
        if (capture) begin
            for (int t = 0; t < T; t++) begin
                a_mem[t] <= a_tri[t*W +: W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || capture) begin
            for (int t = 0; t < T; t++) begin
                l_mem[t] <= '0;              // Factor starts empty
            end
        end else if (wr_en) begin
            l_mem[tri_idx(wr_idx[1], wr_idx[0])] <= wr_data;
        end
    end

    assign rd_a   = a_mem[tri_idx(rd_row, rd_col)];
    assign rd_l0  = l_mem[tri_idx(rd_row, rd_term)];
    assign rd_l1  = l_mem[tri_idx(rd_col, rd_term)];
    assign rd_piv = l_mem[tri_idx(rd_col, rd_col)];

    always_comb begin
        for (int t = 0; t < T; t++) begin
            l_tri[t*W +: W] = l_mem[t];
        end
    end

endmodule

`default_nettype wire

//--- dot_mac.sv
`timescale 1ns/1ps
`default_nettype none

module dot_mac (
    input  logic           clk,
    input  logic           rst,
    input  logic           mac_clear,
    input  logic           mac_step,
    input  chol_pkg::fix_t mac_x,
    input  chol_pkg::fix_t mac_y,
    output chol_pkg::acc_t mac_sum
);

    chol_pkg::acc_t prod;
    chol_pkg::acc_t sum_q;

    // Q16.16 times Q16.16 lands in Q32.32
    assign prod = chol_pkg::acc_t'(mac_x) * chol_pkg::acc_t'(mac_y);

    always_ff @(posedge clk) begin
        if (rst || mac_clear) begin
            sum_q <= '0;
        end else if (mac_step) begin
            sum_q <= sum_q + prod;               // One term per step
        end
    end

    assign mac_sum = sum_q;

endmodule

`default_nettype wire

//--- elem_unit.sv
`timescale 1ns/1ps
`default_nettype none

module elem_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  chol_pkg::elem_req_t req,
    output logic                res_valid,
    output chol_pkg::fix_t      res
);

    chol_pkg::fix_t diff_q;                      // A_ij minus dot product
    chol_pkg::fix_t piv_q;
    logic           diag_q;
    logic           go_q;                        // Start pulse after pre-subtraction
    logic           sq_done;
    logic           dv_done;
    chol_pkg::fix_t sq_root;
    chol_pkg::fix_t dv_quot;

    always_ff @(posedge clk) begin
        if (rst) begin
            go_q <= 1'b0;
        end else begin
            go_q <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            diff_q <= req.a_elem - req.dot;
            piv_q  <= req.pivot;
            diag_q <= req.is_diag;
        end
    end

    fix_sqrt u_sqrt (
        .clk      (clk),
        .rst      (rst),
        .start    (go_q && diag_q),
        .radicand (diff_q),
        .done     (sq_done),
        .root     (sq_root)
    );

    fix_div u_div (
        .clk      (clk),
        .rst      (rst),
        .start    (go_q && !diag_q),
        .dividend (diff_q),
        .divisor  (piv_q),
        .done     (dv_done),
        .quotient (dv_quot)
    );

    // Only one unit runs at a time
    assign res_valid = sq_done || dv_done;
    assign res       = diag_q ? sq_root : dv_quot;

endmodule

`default_nettype wire

//--- fix_div.sv
`timescale 1ns/1ps
`default_nettype none

module fix_div (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  chol_pkg::fix_t dividend,
    input  chol_pkg::fix_t divisor,
    output logic           done,
    output chol_pkg::fix_t quotient
);

    localparam int W     = chol_pkg::FIX_W;
    localparam int NUM_W = chol_pkg::FIX_W + chol_pkg::FRAC_W; // Dividend shifted by 16
    localparam int CNT_W = $clog2(NUM_W);

    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic [NUM_W-1:0] q_q;                       // Numerator out at top, quotient in at bottom
    logic [W-1:0]     rem_q;
    logic [W-1:0]     den_q;
    logic             neg_q;
    logic             zero_q;
    logic [W-1:0]     num_mag;
    logic [W-1:0]     den_mag;
    logic [W:0]       rem_sh;
    logic [W+1:0]     diff;
    logic [NUM_W-1:0] q_signed;

    assign num_mag = dividend[W-1] ? -dividend : dividend;
    assign den_mag = divisor[W-1] ? -divisor : divisor;

    // ======================================================================
    // Step control
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= busy && (cnt == CNT_W'(NUM_W - 1));
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(NUM_W - 1)) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // ======================================================================
    // Restoring datapath
    // ======================================================================
    assign rem_sh = {rem_q, q_q[NUM_W-1]};
    assign diff   = {1'b0, rem_sh} - {2'b00, den_q};

    always_ff @(posedge clk) begin
        if (start) begin
            q_q    <= {num_mag, {chol_pkg::FRAC_W{1'b0}}};
            rem_q  <= '0;
            den_q  <= den_mag;
            neg_q  <= dividend[W-1] ^ divisor[W-1];
            zero_q <= (divisor == '0);
        end else if (busy) begin
            q_q   <= {q_q[NUM_W-2:0], ~diff[W+1]};     // Quotient bit set when it fits
            rem_q <= diff[W+1] ? rem_sh[W-1:0] : diff[W-1:0];
        end
    end

    // Sign applied to the magnitude truncates toward zero
    assign q_signed = neg_q ? -q_q : q_q;
    assign quotient = zero_q ? '0 : chol_pkg::fix_t'(q_signed[W-1:0]);

endmodule

`default_nettype wire

//--- fix_sqrt.sv
`timescale 1ns/1ps
`default_nettype none

module fix_sqrt (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  chol_pkg::fix_t radicand,
    output logic           done,
    output chol_pkg::fix_t root
);

    localparam int RAD_W  = chol_pkg::FIX_W + chol_pkg::FRAC_W; // Radicand times 2^16
    localparam int ROOT_W = RAD_W / 2;
    localparam int CNT_W  = $clog2(ROOT_W);

    logic              busy;
    logic [CNT_W-1:0]  cnt;
    logic [RAD_W-1:0]  rad_q;                    // Consumed two bits per step
    logic [ROOT_W+2:0] rem_q;
    logic [ROOT_W-1:0] root_q;
    logic [ROOT_W+2:0] rem_sh;
    logic [ROOT_W+2:0] trial;

    assign rem_sh = {rem_q[ROOT_W:0], rad_q[RAD_W-1 -: 2]};
    assign trial  = {1'b0, root_q, 2'b01};       // 4*root + 1

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= busy && (cnt == CNT_W'(ROOT_W - 1));
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(ROOT_W - 1)) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rad_q  <= radicand[chol_pkg::FIX_W-1] ? '0 : {radicand, {chol_pkg::FRAC_W{1'b0}}};
            rem_q  <= '0;
            root_q <= '0;
        end else if (busy) begin
            rad_q <= {rad_q[RAD_W-3:0], 2'b00};
            if (rem_sh >= trial) begin
                rem_q  <= rem_sh - trial;
                root_q <= {root_q[ROOT_W-2:0], 1'b1};
            end else begin
                rem_q  <= rem_sh;
                root_q <= {root_q[ROOT_W-2:0], 1'b0};
            end
        end
    end

    assign root = chol_pkg::fix_t'({{(chol_pkg::FIX_W - ROOT_W){1'b0}}, root_q});

endmodule

`default_nettype wire

//--- chol_pkg.sv
`default_nettype none

package chol_pkg;

    // ======================================================================
    // Fixed-point widths
    // ======================================================================
    localparam int FIX_W     = 32;              // One matrix element
    localparam int FRAC_W    = 16;              // Q16.16 fraction bits
    localparam int ACC_W     = 64;              // Products and running sums
    localparam int DEFAULT_N = 5;               // Default matrix order

    typedef logic signed [FIX_W-1:0] fix_t;     // Signed Q16.16
    typedef logic signed [ACC_W-1:0] acc_t;     // Signed Q32.32
    typedef logic [3:0]              idx_t;     // Row, column or term, N up to 15

    // ======================================================================
    // Element operation request
    // ======================================================================
    typedef struct packed {
        logic is_diag;                          // Square root when set, else divide
        fix_t a_elem;                           // A_ij
        fix_t dot;                              // Running sum bits 47..16
        fix_t pivot;                            // L_jj, divisor of the column
    } elem_req_t;

    typedef enum logic [2:0] {
        IDLE,
        DOT_CLEAR,
        DOT_STEP,
        DOT_WAIT,
        ELEM_ISSUE,
        ELEM_WAIT,
        WRITE,
        DONE
    } seq_state_e;

endpackage

`default_nettype wire
